/* source/wbuf_pkg.sv */
`default_nettype none

package wbuf_pkg;

    // cache-side accept stage
    typedef enum logic {
        ACC_IDLE = 1'b0,
        ACC_ACK  = 1'b1
    } accept_state_t;

    // bus-side drain stage
    typedef enum logic [1:0] {
        DRN_IDLE = 2'd0,
        DRN_ADDR = 2'd1,
        DRN_DATA = 2'd2,
        DRN_RESP = 2'd3
    } drain_state_t;

endpackage

`default_nettype wire

/* source/wbuf_entry_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface wbuf_entry_if #(
    parameter int OFFSET_WIDTH = 2
);
    localparam int LINE_W = 32 << OFFSET_WIDTH;

    logic              push;
    logic [31:0]       addr;
    logic [LINE_W-1:0] data;
    // store has no free slot
    logic              full;

    modport src (
        output push, addr, data,
        input  full
    );

    modport dst (
        input  push, addr, data,
        output full
    );

endinterface

`default_nettype wire

/* source/wbuf_head_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface wbuf_head_if #(
    parameter int OFFSET_WIDTH = 2
);
    localparam int LINE_W = 32 << OFFSET_WIDTH;

    logic              nonempty;
    // oldest occupied slot
    logic [31:0]       head_addr;
    logic [LINE_W-1:0] head_data;
    logic              pop;

    modport src (
        output nonempty, head_addr, head_data,
        input  pop
    );

    modport dst (
        input  nonempty, head_addr, head_data,
        output pop
    );

endinterface

`default_nettype wire

/* source/wbuf_accept.sv */
`timescale 1ns/1ps
`default_nettype none

module wbuf_accept
    import wbuf_pkg::*;
#(
    parameter int OFFSET_WIDTH = 2
) (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic [31:0]                  in_addr,
    input  logic [(32<<OFFSET_WIDTH)-1:0] in_data,
    input  logic                         in_valid,
    output logic                         in_ready,
    wbuf_entry_if.src                    entry
);

    accept_state_t state;
    accept_state_t state_nxt;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= ACC_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt  = state;
        entry.push = 1'b0;
        in_ready   = 1'b0;
        case (state)
            ACC_IDLE: begin
                // hold off while the store is full
                if (in_valid && !entry.full) begin
                    entry.push = 1'b1;
                    state_nxt  = ACC_ACK;
                end
            end
            ACC_ACK: begin
                // one-cycle ack on which the cache drops in_valid
                in_ready  = 1'b1;
                state_nxt = ACC_IDLE;
            end
            default: begin
                state_nxt = ACC_IDLE;
            end
        endcase
    end

    assign entry.addr = in_addr;
    assign entry.data = in_data;

endmodule

`default_nettype wire

/* source/wbuf_store.sv */
`timescale 1ns/1ps
`default_nettype none

module wbuf_store #(
    parameter int DEPTH        = 5,
    parameter int OFFSET_WIDTH = 2
) (
    input  logic                         clk,
    input  logic                         rstn,
    wbuf_entry_if.dst                    entry,
    wbuf_head_if.src                     head,
    input  logic [31:0]                  query_addr,
    output logic [(32<<OFFSET_WIDTH)-1:0] query_data,
    output logic                         query_ok
);

    localparam int LINE_W = 32 << OFFSET_WIDTH;
    localparam int CNT_W  = $clog2(DEPTH + 1);
    localparam int IDX_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // slot 0 is the newest line
    logic [31:0]       addr_q [DEPTH];
    logic [LINE_W-1:0] data_q [DEPTH];
    logic [CNT_W-1:0]  count;
    logic [IDX_W-1:0]  head_idx;

    // shift insert drops the deepest slot
    always_ff @(posedge clk) begin
        if (entry.push) begin
            addr_q[0] <= entry.addr;
            data_q[0] <= entry.data;
            for (int i = 1; i < DEPTH; i++) begin
                addr_q[i] <= addr_q[i-1];
                data_q[i] <= data_q[i-1];
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            count <= '0;
        end else begin
            case ({entry.push, head.pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                // push with pop keeps the count
                default: count <= count;
            endcase
        end
    end

    assign entry.full = (count == CNT_W'(DEPTH));

    // oldest entry sits at count-1
    assign head_idx       = (count == '0) ? '0 : IDX_W'(count - 1'b1);
    assign head.nonempty  = (count != '0);
    assign head.head_addr = addr_q[head_idx];
    assign head.head_data = data_q[head_idx];

    // newest-first search over occupied slots
    always_comb begin
        query_ok   = 1'b0;
        query_data = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if ((CNT_W'(i) < count) && (addr_q[i] == query_addr)) begin
                query_ok   = 1'b1;
                query_data = data_q[i];
            end
        end
    end

endmodule

`default_nettype wire

/* source/wbuf_drain.sv */
`timescale 1ns/1ps
`default_nettype none

module wbuf_drain
    import wbuf_pkg::*;
#(
    parameter int OFFSET_WIDTH = 2
) (
    input  logic        clk,
    input  logic        rstn,
    wbuf_head_if.dst    head,
    input  logic        dma_lock,
    input  logic        out_awready,
    input  logic        out_wready,
    input  logic        out_bvalid,
    output logic [31:0] out_addr,
    output logic [31:0] out_data,
    output logic        out_valid,
    output logic        out_last,
    output logic        out_bready,
    output logic        wrt_lock
);

    localparam int LINE_W = 32 << OFFSET_WIDTH;
    localparam int WORDS  = 1 << OFFSET_WIDTH;
    localparam int BEAT_W = (OFFSET_WIDTH > 0) ? OFFSET_WIDTH : 1;

    drain_state_t      state;
    drain_state_t      state_nxt;
    logic [BEAT_W-1:0] beat;
    logic              beat_last;
    logic [31:0]       addr_q;
    logic [LINE_W-1:0] line_q;

    assign beat_last = (beat == BEAT_W'(WORDS - 1));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= DRN_IDLE;
            beat  <= '0;
        end else begin
            state <= state_nxt;
            if (state == DRN_ADDR) begin
                beat <= '0;
            end else if (state == DRN_DATA && out_wready && !beat_last) begin
                beat <= beat + 1'b1;
            end
        end
    end

    // popped line is held here for the whole burst
    always_ff @(posedge clk) begin
        if (head.pop) begin
            addr_q <= head.head_addr;
            line_q <= head.head_data;
        end
    end

    always_comb begin
        state_nxt = state;
        head.pop  = 1'b0;
        case (state)
            DRN_IDLE: begin
                // dma master owns the bus while dma_lock is high
                if (!dma_lock && head.nonempty) begin
                    head.pop  = 1'b1;
                    state_nxt = DRN_ADDR;
                end
            end
            DRN_ADDR: begin
                if (out_awready) begin
                    state_nxt = DRN_DATA;
                end
            end
            DRN_DATA: begin
                if (out_wready && beat_last) begin
                    state_nxt = DRN_RESP;
                end
            end
            DRN_RESP: begin
                if (out_bvalid) begin
                    state_nxt = DRN_IDLE;
                end
            end
            default: begin
                state_nxt = DRN_IDLE;
            end
        endcase
    end

    assign out_valid  = (state == DRN_ADDR) || (state == DRN_DATA);
    assign out_addr   = (state == DRN_ADDR) ? addr_q : 32'd0;
    // lowest word goes first
    assign out_data   = (state == DRN_DATA) ? line_q[32*beat +: 32] : 32'd0;
    assign out_last   = (state == DRN_DATA) && beat_last;
    assign out_bready = (state == DRN_RESP);
    // lock rises together with the pop
    assign wrt_lock   = (state != DRN_IDLE) || head.pop;

endmodule

`default_nettype wire

/* source/write_buffer_top.sv */
`timescale 1ns/1ps
`default_nettype none

module write_buffer_top #(
    parameter int DEPTH        = 5,
    parameter int OFFSET_WIDTH = 2
) (
    input  logic                         clk,
    input  logic                         rstn,
    // cache side
    input  logic [31:0]                  in_addr,
    input  logic [(32<<OFFSET_WIDTH)-1:0] in_data,
    input  logic                         in_valid,
    output logic                         in_ready,
    // memory bus
    output logic [31:0]                  out_addr,
    output logic [31:0]                  out_data,
    output logic                         out_valid,
    input  logic                         out_awready,
    input  logic                         out_wready,
    output logic                         out_last,
    input  logic                         out_bvalid,
    output logic                         out_bready,
    // lookup
    input  logic [31:0]                  query_addr,
    output logic [(32<<OFFSET_WIDTH)-1:0] query_data,
    output logic                         query_ok,
    // bus ownership against the dma master
    input  logic                         dma_lock,
    output logic                         wrt_lock
);

    wbuf_entry_if #(.OFFSET_WIDTH(OFFSET_WIDTH)) entry_bus ();
    wbuf_head_if  #(.OFFSET_WIDTH(OFFSET_WIDTH)) head_bus ();

    wbuf_accept #(
        .OFFSET_WIDTH(OFFSET_WIDTH)
    ) wbuf_accept_inst (
        .clk      (clk),
        .rstn     (rstn),
        .in_addr  (in_addr),
        .in_data  (in_data),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .entry    (entry_bus.src)
    );

    wbuf_store #(
        .DEPTH        (DEPTH),
        .OFFSET_WIDTH (OFFSET_WIDTH)
    ) wbuf_store_inst (
        .clk        (clk),
        .rstn       (rstn),
        .entry      (entry_bus.dst),
        .head       (head_bus.src),
        .query_addr (query_addr),
        .query_data (query_data),
        .query_ok   (query_ok)
    );

    wbuf_drain #(
        .OFFSET_WIDTH(OFFSET_WIDTH)
    ) wbuf_drain_inst (
        .clk         (clk),
        .rstn        (rstn),
        .head        (head_bus.dst),
        .dma_lock    (dma_lock),
        .out_awready (out_awready),
        .out_wready  (out_wready),
        .out_bvalid  (out_bvalid),
        .out_addr    (out_addr),
        .out_data    (out_data),
        .out_valid   (out_valid),
        .out_last    (out_last),
        .out_bready  (out_bready),
        .wrt_lock    (wrt_lock)
    );

endmodule

`default_nettype wire

/* tb/bus_slave_model.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_slave_model #(
    parameter int OFFSET_WIDTH = 2
) (
    input  logic        clk,
    input  logic        rstn,
    input  logic [31:0] out_addr,
    input  logic [31:0] out_data,
    input  logic        out_valid,
    input  logic        out_last,
    input  logic        out_bready,
    output logic        out_awready,
    output logic        out_wready,
    output logic        out_bvalid
);

    localparam int WORDS  = 1 << OFFSET_WIDTH;
    localparam int LINE_W = 32 << OFFSET_WIDTH;

    // completed bursts, oldest first
    logic [31:0]       rec_addr [$];
    logic [LINE_W-1:0] rec_line [$];
    int                last_errors = 0;
    int                phase = 0;
    int                beat = 0;
    logic [31:0]       cur_addr;
    logic [LINE_W-1:0] cur_line;

    initial begin
        out_awready = 1'b0;
        out_wready  = 1'b0;
        out_bvalid  = 1'b0;
    end

    always @(posedge clk) begin
        if (!rstn) begin
            phase = 0;
            beat  = 0;
        end else if (phase == 0 && out_valid && out_awready) begin
            cur_addr = out_addr;
            beat     = 0;
            phase    = 1;
        end else if (phase == 1 && out_valid && out_wready) begin
            cur_line[32*beat +: 32] = out_data;
            // last must sit on the final beat only
            if (out_last != (beat == WORDS - 1)) begin
                last_errors++;
            end
            beat++;
            if (beat == WORDS) begin
                phase = 2;
            end
        end else if (phase == 2 && out_bready && out_bvalid) begin
            rec_addr.push_back(cur_addr);
            rec_line.push_back(cur_line);
            phase = 0;
        end
        #1;
        // random stalls on every channel
        out_awready = (phase == 0) && ($urandom % 3 != 0);
        out_wready  = (phase == 1) && ($urandom % 3 != 0);
        out_bvalid  = (phase == 2) && ($urandom % 2 != 0);
    end

endmodule

`default_nettype wire

/* tb/wbuf_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module wbuf_checker #(
    parameter int DEPTH      = 5,
    parameter bit DRAIN_SIDE = 1'b1
) (
    input logic        clk,
    input logic        rstn,
    input logic        out_valid,
    input logic        out_last,
    input logic        out_bready,
    input logic        wrt_lock,
    input logic        dma_lock,
    input logic        drn_idle,
    input logic [31:0] count
);

    int assert_fails = 0;

    if (DRAIN_SIDE) begin : g_drain
        last_with_valid: assert property (@(posedge clk) disable iff (!rstn)
            out_last |-> out_valid)
            else begin
                assert_fails++;
                $error("out_last without out_valid");
            end

        lock_held: assert property (@(posedge clk) disable iff (!rstn)
            (out_valid || out_bready) |-> wrt_lock)
            else begin
                assert_fails++;
                $error("bus used without wrt_lock");
            end

        // drain stays quiet while dma owns the bus
        dma_exclusion: assert property (@(posedge clk) disable iff (!rstn)
            (drn_idle && dma_lock) |=> !out_valid)
            else begin
                assert_fails++;
                $error("out_valid under dma_lock");
            end
    end else begin : g_store
        count_bound: assert property (@(posedge clk) disable iff (!rstn)
            count <= DEPTH)
            else begin
                assert_fails++;
                $error("count above depth");
            end
    end

endmodule

bind wbuf_drain wbuf_checker #(.DRAIN_SIDE(1'b1)) drain_chk (
    .clk(clk), .rstn(rstn), .out_valid(out_valid), .out_last(out_last),
    .out_bready(out_bready), .wrt_lock(wrt_lock), .dma_lock(dma_lock),
    .drn_idle(state == wbuf_pkg::DRN_IDLE), .count(32'd0)
);

bind wbuf_store wbuf_checker #(.DEPTH(DEPTH), .DRAIN_SIDE(1'b0)) store_chk (
    .clk(clk), .rstn(rstn), .out_valid(1'b0), .out_last(1'b0), .out_bready(1'b0),
    .wrt_lock(1'b0), .dma_lock(1'b0), .drn_idle(1'b0), .count(32'(count))
);

`default_nettype wire

/* tb/tb_write_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_write_buffer;

    localparam int DEPTH = 5;
    localparam int OFFSET_WIDTH = 2;
    localparam int LINE_W = 32 << OFFSET_WIDTH;
    localparam int TIMEOUT = 300;
    localparam int WINDOW = 20;

    typedef enum {OP_INSERT, OP_QUERY, OP_LOCK, OP_UNLOCK, OP_WAIT_DRAINED, OP_STALL} op_t;
    typedef struct packed {
        op_t         op;
        logic [31:0] addr;
        bit          exp_hit;
    } row_t;

    logic clk = 1'b0;
    logic rstn, in_valid, in_ready, out_valid, out_awready, out_wready, out_last;
    logic out_bvalid, out_bready, query_ok, dma_lock, wrt_lock;
    logic [31:0] in_addr, out_addr, out_data, query_addr;
    logic [LINE_W-1:0] in_data, query_data;

    row_t rows [$];
    logic [31:0] model_addr [$];
    logic [LINE_W-1:0] model_line [$];
    bit pending = 0;
    int errs, pass_count = 0, fail_count = 0;

    always #2 clk = ~clk;

    write_buffer_top #(.DEPTH(DEPTH), .OFFSET_WIDTH(OFFSET_WIDTH)) write_buffer_top_inst (
        .clk(clk), .rstn(rstn), .in_addr(in_addr), .in_data(in_data), .in_valid(in_valid),
        .in_ready(in_ready), .out_addr(out_addr), .out_data(out_data),
        .out_valid(out_valid), .out_awready(out_awready), .out_wready(out_wready),
        .out_last(out_last), .out_bvalid(out_bvalid), .out_bready(out_bready),
        .query_addr(query_addr), .query_data(query_data), .query_ok(query_ok),
        .dma_lock(dma_lock), .wrt_lock(wrt_lock)
    );

    bus_slave_model #(.OFFSET_WIDTH(OFFSET_WIDTH)) slave_inst (
        .clk(clk), .rstn(rstn), .out_addr(out_addr), .out_data(out_data),
        .out_valid(out_valid), .out_last(out_last), .out_bready(out_bready),
        .out_awready(out_awready), .out_wready(out_wready), .out_bvalid(out_bvalid)
    );

    function automatic void add_row(op_t op, logic [31:0] addr, bit hit);
        row_t r;
        r.op = op;
        r.addr = addr;
        r.exp_hit = hit;
        rows.push_back(r);
    endfunction

    task automatic record_result(input string name);
        $display("%s: %s", name, errs == 0 ? "ok" : "failed");
        if (errs == 0) begin
            pass_count++;
        end else begin
            fail_count++;
        end
    endtask

    // waits for the single in_ready pulse and drops in_valid
    task automatic take_ready(input string name);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!in_ready && n < TIMEOUT);
        if (!in_ready) begin
            $display("%s: in_ready never came", name);
            errs++;
        end
        @(posedge clk);
        #1 in_valid = 1'b0;
        model_addr.push_front(in_addr);
        model_line.push_front(in_data);
        @(negedge clk);
        if (in_ready) begin
            $display("%s: in_ready longer than one cycle", name);
            errs++;
        end
    endtask

    task automatic raise_line(input logic [31:0] addr);
        in_addr = addr;
        for (int w = 0; w < (1 << OFFSET_WIDTH); w++) begin
            in_data[32*w +: 32] = $urandom;
        end
        in_valid = 1'b1;
    endtask

    task automatic check_query(input string name, input logic [31:0] addr, input bit hit);
        logic [LINE_W-1:0] exp_data;
        exp_data = '0;
        // newest copy sits at the queue front
        for (int i = model_addr.size() - 1; i >= 0; i--) begin
            if (model_addr[i] == addr) begin
                exp_data = model_line[i];
            end
        end
        query_addr = addr;
        #1;
        if (query_ok !== hit || query_data !== exp_data) begin
            $display("[ERROR] %s expected ok=%0b data=%h actual ok=%0b data=%h",
                     name, hit, exp_data, query_ok, query_data);
            errs++;
        end
    endtask

    task automatic wait_drained(input string name);
        int n;
        logic [31:0] a;
        logic [LINE_W-1:0] l;
        if (pending) begin
            take_ready(name);
            pending = 0;
        end
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while ((slave_inst.rec_addr.size() < model_addr.size() || wrt_lock)
                   && n < TIMEOUT * 4);
        if (slave_inst.rec_addr.size() < model_addr.size()) begin
            $display("%s: buffer did not drain in time", name);
            errs++;
        end
        while (slave_inst.rec_addr.size() > 0 && model_addr.size() > 0) begin
            a = model_addr.pop_back();
            l = model_line.pop_back();
            if (slave_inst.rec_addr[0] !== a || slave_inst.rec_line[0] !== l) begin
                $display("[ERROR] %s expected %h:%h actual %h:%h", name, a, l,
                         slave_inst.rec_addr[0], slave_inst.rec_line[0]);
                errs++;
            end
            void'(slave_inst.rec_addr.pop_front());
            void'(slave_inst.rec_line.pop_front());
        end
        if (slave_inst.last_errors != 0) begin
            $display("%s: out_last seen on a wrong beat", name);
            errs++;
        end
    endtask

    task automatic check_stall(input string name);
        repeat (WINDOW) begin
            @(negedge clk);
            if (out_valid || wrt_lock || in_ready) begin
                $display("%s: bus activity or in_ready during stall window", name);
                errs++;
            end
        end
    endtask

    initial begin
        void'($urandom(6206));
        rstn = 1'b0;
        in_valid = 1'b0;
        in_addr = '0;
        in_data = '0;
        query_addr = 32'h0000_0abc;
        dma_lock = 1'b1;
        repeat (3) @(posedge clk);
        #1 rstn = 1'b1;
        @(negedge clk);
        errs = 0;
        if ({in_ready, out_valid, out_last, out_bready, wrt_lock, query_ok} !== 6'b0) begin
            $display("[ERROR] reset_state expected 000000 actual %b%b%b%b%b%b",
                     in_ready, out_valid, out_last, out_bready, wrt_lock, query_ok);
            errs++;
        end
        record_result("reset_state");

        add_row(OP_LOCK, 0, 0);
        add_row(OP_INSERT, 32'h100, 0);
        add_row(OP_INSERT, 32'h200, 0);
        add_row(OP_INSERT, 32'h300, 0);
        add_row(OP_QUERY, 32'h100, 1);
        add_row(OP_QUERY, 32'h200, 1);
        add_row(OP_QUERY, 32'h300, 1);
        add_row(OP_QUERY, 32'h400, 0);
        add_row(OP_INSERT, 32'h200, 0);
        add_row(OP_QUERY, 32'h200, 1);
        add_row(OP_STALL, 0, 0);
        add_row(OP_UNLOCK, 0, 0);
        add_row(OP_WAIT_DRAINED, 0, 0);
        add_row(OP_LOCK, 0, 0);
        for (int i = 0; i < DEPTH; i++) begin
            add_row(OP_INSERT, 32'h1000 + 16 * i, 0);
        end
        add_row(OP_STALL, 32'h2000, 0);
        add_row(OP_UNLOCK, 0, 0);
        add_row(OP_WAIT_DRAINED, 0, 0);
        add_row(OP_QUERY, 32'h2000, 0);

        foreach (rows[i]) begin
            string name;
            name = $sformatf("row%0d_%s", i, rows[i].op.name());
            errs = 0;
            @(posedge clk);
            #1;
            case (rows[i].op)
                OP_INSERT: begin
                    raise_line(rows[i].addr);
                    take_ready(name);
                end
                OP_QUERY: check_query(name, rows[i].addr, rows[i].exp_hit);
                OP_LOCK: dma_lock = 1'b1;
                OP_UNLOCK: dma_lock = 1'b0;
                OP_WAIT_DRAINED: wait_drained(name);
                default: begin
                    // a nonzero address holds one more line against a full buffer
                    if (rows[i].addr != 0) begin
                        raise_line(rows[i].addr);
                        pending = 1;
                    end
                    check_stall(name);
                end
            endcase
            record_result(name);
        end

        if (write_buffer_top_inst.wbuf_drain_inst.drain_chk.assert_fails != 0 ||
            write_buffer_top_inst.wbuf_store_inst.store_chk.assert_fails != 0) begin
            $display("bound checker assertions failed during the run");
            fail_count++;
        end

        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
source/wbuf_pkg.sv
source/wbuf_entry_if.sv
source/wbuf_head_if.sv
source/wbuf_accept.sv
source/wbuf_store.sv
source/wbuf_drain.sv
source/write_buffer_top.sv
tb/bus_slave_model.sv
tb/wbuf_checker.sv
tb/tb_write_buffer.sv
